// File: design/unpack_pkg.sv
package unpack_pkg;

    // bus and field widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    // bram address, also read counts and packet depths
    typedef logic [10:0] bram_addr_t;
    typedef logic [15:0] basis_count_t;
    typedef logic [8:0]  short_depth_t;

    // packet type codes, other values unknown
    typedef enum logic [3:0] {
        z_basis       = 4'd1,
        x_basis       = 4'd2,
        ask_parity    = 4'd3,
        verif_hashtag = 4'd4
    } pkt_type_e;

    // length codes, anything above len_1028 treated as len_1028
    typedef enum logic [3:0] {
        len_257  = 4'd0,
        len_514  = 4'd1,
        len_771  = 4'd2,
        len_1028 = 4'd3
    } len_code_e;

    // header word layout
    // body holds short depth (23:15) and basis count (15:0), bit 15 shared
    typedef struct packed {
        pkt_type_e  pkt_type;
        len_code_e  len_code;
        logic [23:0] body;
    } rx_header_t;

    // reader to router word stream
    typedef struct packed {
        logic  valid;
        logic  is_header;
        word_t data;
    } word_stream_t;

    // fifo write ports, no back-pressure
    typedef struct packed {
        logic  en;
        word_t din;
    } fifo_wr32_t;

    typedef struct packed {
        logic   en;
        dword_t din;
    } fifo_wr64_t;

    typedef enum logic [3:0] {
        idle         = 4'd0,
        read_header  = 4'd1,
        set_up       = 4'd2,
        stream       = 4'd3,
        done         = 4'd4,
        wait_release = 4'd5
    } unpack_state_e;

    // overlapping header fields
    function automatic short_depth_t hdr_short_depth(rx_header_t h);
        return h.body[23:15];
    endfunction

    function automatic basis_count_t hdr_basis_count(rx_header_t h);
        return h.body[15:0];
    endfunction

endpackage

// File: design/unpack_fsm.sv
`timescale 1ns/100ps

module unpack_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      busy_net,
    input  logic                      msg_accessed,
    input  logic                      stream_done,
    output logic                      busy,
    output logic                      read_header_en,
    output logic                      stream_en,
    output logic                      clear_packet,
    output unpack_pkg::unpack_state_e state
);
    import unpack_pkg::*;

    unpack_state_e next_state;

    // state register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // next state and phase strobes
    always_comb begin
        next_state     = state;
        read_header_en = 1'b0;
        stream_en      = 1'b0;
        clear_packet   = 1'b0;
        case (state)
            idle: begin
                // packet waiting and network side free
                if (msg_accessed && !busy_net) begin
                    next_state = read_header;
                end
            end
            read_header: begin
                // header word sits in the reader's data register
                read_header_en = 1'b1;
                next_state     = set_up;
            end
            set_up: begin
                // one cycle for the depth decode to settle
                next_state = stream;
            end
            stream: begin
                // counter keeps running in the done cycle too
                stream_en = 1'b1;
                if (stream_done) begin
                    next_state = done;
                end
            end
            done: begin
                clear_packet = 1'b1;
                next_state   = wait_release;
            end
            wait_release: begin
                // hold until the network side drops the packet
                if (!msg_accessed) begin
                    next_state = idle;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    // low only while idle
    assign busy = (state != idle);

endmodule

// File: design/bram_reader.sv
`timescale 1ns/100ps

module bram_reader (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     read_header_en,
    input  logic                     stream_en,
    input  logic                     clear_packet,
    input  unpack_pkg::word_t        bram_dout,
    output unpack_pkg::bram_addr_t   bram_addr,
    output unpack_pkg::rx_header_t   header,
    output unpack_pkg::word_stream_t words,
    output logic                     stream_done
);
    import unpack_pkg::*;

    word_t      bram_q;
    bram_addr_t depth;
    bram_addr_t read_cnt;
    logic       addr_win;
    logic       word_win;

    // one stage after the ram's own output
    always_ff @(posedge clk) begin
        bram_q <= bram_dout;
    end

    // header capture, address is 0 while idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            header <= '0;
        end else if (read_header_en) begin
            header <= rx_header_t'(bram_q);
        end else if (clear_packet) begin
            header <= '0;
        end
    end

    // depth from the length code
    always_comb begin
        case (header.len_code)
            len_257: depth = bram_addr_t'(hdr_short_depth(header));
            len_514: depth = 11'd512;
            len_771: depth = 11'd768;
            default: depth = 11'd1024;
        endcase
    end

    // read counter, runs through the stream phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_cnt <= '0;
        end else if (clear_packet) begin
            read_cnt <= '0;
        end else if (stream_en) begin
            read_cnt <= read_cnt + 11'd1;
        end
    end

    // address k loaded at count k+3
    assign addr_win = (read_cnt >= 11'd3) && (read_cnt <= depth + 11'd3);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bram_addr <= '0;
        end else if (addr_win) begin
            bram_addr <= read_cnt - 11'd3;
        end else begin
            bram_addr <= '0;
        end
    end

    // address k returns in bram_q at count k+6
    // registered here so word k shows at count k+7
    assign word_win = (read_cnt >= 11'd6) && (read_cnt < depth + 11'd7);

    always_ff @(posedge clk) begin
        words.data <= bram_q;
        if (!rst_n) begin
            words.valid     <= 1'b0;
            words.is_header <= 1'b0;
        end else begin
            words.valid     <= word_win;
            words.is_header <= (read_cnt == 11'd6);
        end
    end

    // two spare cycles after the last word
    assign stream_done = (read_cnt == depth + 11'd9);

endmodule

// File: design/fifo_router.sv
`timescale 1ns/100ps

module fifo_router #(
    parameter unpack_pkg::basis_count_t x_full_count = 16'd63,
    parameter unpack_pkg::basis_count_t z_full_count = 16'd31
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  unpack_pkg::rx_header_t   header,
    input  unpack_pkg::word_stream_t words,
    input  logic                     clear_packet,
    input  logic                     reset_sift,
    output unpack_pkg::fifo_wr32_t   z_wr,
    output unpack_pkg::fifo_wr32_t   er_wr,
    output unpack_pkg::fifo_wr64_t   x_wr,
    output logic                     sift_full
);
    import unpack_pkg::*;

    logic         is_er;
    logic         is_z;
    logic         is_x;
    logic         payload;
    logic         pair_sel;
    word_t        prev_word;
    basis_count_t x_count;
    basis_count_t z_count;

    // packet type decode
    assign is_er = (header.pkt_type == ask_parity) || (header.pkt_type == verif_hashtag);
    assign is_z  = (header.pkt_type == z_basis);
    assign is_x  = (header.pkt_type == x_basis);

    // stream word past the header
    assign payload = words.valid && !words.is_header;

    // er stream keeps the header word
    assign er_wr.en  = is_er && words.valid;
    assign er_wr.din = er_wr.en ? words.data : '0;

    // z fifo, one payload word per write
    assign z_wr.en  = is_z && payload;
    assign z_wr.din = z_wr.en ? words.data : '0;

    // pair toggle, high on the second word of a pair
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pair_sel <= 1'b0;
        end else if (clear_packet) begin
            pair_sel <= 1'b0;
        end else if (payload) begin
            pair_sel <= !pair_sel;
        end
    end

    // earlier word of the pair
    always_ff @(posedge clk) begin
        if (payload) begin
            prev_word <= words.data;
        end
    end

    // earlier word in the upper half
    assign x_wr.en  = is_x && payload && pair_sel;
    assign x_wr.din = x_wr.en ? {prev_word, words.data} : '0;

    // basis counts follow the latest x and z headers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_count <= '0;
            z_count <= '0;
        end else if (reset_sift) begin
            x_count <= '0;
            z_count <= '0;
        end else begin
            if (is_x) begin
                x_count <= hdr_basis_count(header);
            end
            if (is_z) begin
                z_count <= hdr_basis_count(header);
            end
        end
    end

    // both thresholds reached
    assign sift_full = (x_count == x_full_count) && (z_count == z_full_count);

endmodule

// File: design/unpacket_top.sv
`timescale 1ns/100ps

module unpacket_top #(
    parameter unpack_pkg::basis_count_t x_full_count = 16'd63,
    parameter unpack_pkg::basis_count_t z_full_count = 16'd31
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      busy_net,
    input  logic                      msg_accessed,
    input  logic                      reset_sift,
    input  unpack_pkg::word_t         bram_dout,
    output logic                      busy,
    output unpack_pkg::bram_addr_t    bram_addr,
    output unpack_pkg::fifo_wr32_t    z_wr,
    output unpack_pkg::fifo_wr32_t    er_wr,
    output unpack_pkg::fifo_wr64_t    x_wr,
    output logic                      sift_full,
    output unpack_pkg::unpack_state_e unpack_state
);
    import unpack_pkg::*;

    // fsm phase strobes
    logic read_header_en;
    logic stream_en;
    logic clear_packet;
    logic stream_done;

    // reader to router
    rx_header_t   header;
    word_stream_t words;

    unpack_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .busy_net       (busy_net),
        .msg_accessed   (msg_accessed),
        .stream_done    (stream_done),
        .busy           (busy),
        .read_header_en (read_header_en),
        .stream_en      (stream_en),
        .clear_packet   (clear_packet),
        .state          (unpack_state)
    );

    bram_reader u_reader (
        .clk            (clk),
        .rst_n          (rst_n),
        .read_header_en (read_header_en),
        .stream_en      (stream_en),
        .clear_packet   (clear_packet),
        .bram_dout      (bram_dout),
        .bram_addr      (bram_addr),
        .header         (header),
        .words          (words),
        .stream_done    (stream_done)
    );

    fifo_router #(
        .x_full_count (x_full_count),
        .z_full_count (z_full_count)
    ) u_router (
        .clk          (clk),
        .rst_n        (rst_n),
        .header       (header),
        .words        (words),
        .clear_packet (clear_packet),
        .reset_sift   (reset_sift),
        .z_wr         (z_wr),
        .er_wr        (er_wr),
        .x_wr         (x_wr),
        .sift_full    (sift_full)
    );

endmodule

// File: verif/rx_bram_model.sv
`timescale 1ns/100ps

module rx_bram_model (
    input  logic                   clk,
    input  unpack_pkg::bram_addr_t addr,
    output unpack_pkg::word_t      dout
);
    import unpack_pkg::*;

    // full 11-bit address space
    // contents written directly by the testbench
    word_t mem [0:2047];

    // one-cycle read latency, like the rx block ram
    always_ff @(posedge clk) begin
        dout <= mem[addr];
    end

endmodule

// File: verif/tb_unpacket.sv
`timescale 1ns/100ps

module tb_unpacket;
    import unpack_pkg::*;

    localparam int num_pkts = 6;

    // one row of the packet table
    typedef struct packed {
        logic [3:0]   pkt_type;
        logic [3:0]   len_code;
        logic [8:0]   short_depth;
        basis_count_t basis_count;
        logic [3:0]   hold;
        logic         exp_sift;
    } pkt_entry_t;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          busy_net;
    logic          msg_accessed;
    logic          reset_sift;
    word_t         bram_dout;
    logic          busy;
    bram_addr_t    bram_addr;
    fifo_wr32_t    z_wr;
    fifo_wr32_t    er_wr;
    fifo_wr64_t    x_wr;
    logic          sift_full;
    unpack_state_e unpack_state;

    pkt_entry_t pkt_table [num_pkts];
    // predicted fifo writes in arrival order
    word_t      exp_z [$];
    word_t      exp_er [$];
    dword_t     exp_x [$];
    int         n_checks = 0;
    int         n_errors = 0;
    int         cycles = 0;
    int         limit = 0;

    unpacket_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .busy_net     (busy_net),
        .msg_accessed (msg_accessed),
        .reset_sift   (reset_sift),
        .bram_dout    (bram_dout),
        .busy         (busy),
        .bram_addr    (bram_addr),
        .z_wr         (z_wr),
        .er_wr        (er_wr),
        .x_wr         (x_wr),
        .sift_full    (sift_full),
        .unpack_state (unpack_state)
    );

    rx_bram_model bram (
        .clk  (clk),
        .addr (bram_addr),
        .dout (bram_dout)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        n_errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    // payload depth from the length code
    function automatic int pkt_depth(input logic [3:0] len_code, input logic [8:0] short_depth);
        case (len_code)
            4'd0:    return int'(short_depth);
            4'd1:    return 512;
            4'd2:    return 768;
            default: return 1024;
        endcase
    endfunction

    // fifo scoreboards on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (z_wr.en) begin
                if (exp_z.size() == 0) begin
                    report_error("unexpected write on z_wr");
                end else begin
                    check_value("z_wr.din", 64'(z_wr.din), 64'(exp_z.pop_front()));
                end
            end
            if (er_wr.en) begin
                if (exp_er.size() == 0) begin
                    report_error("unexpected write on er_wr");
                end else begin
                    check_value("er_wr.din", 64'(er_wr.din), 64'(exp_er.pop_front()));
                end
            end
            if (x_wr.en) begin
                if (exp_x.size() == 0) begin
                    report_error("unexpected write on x_wr");
                end else begin
                    check_value("x_wr.din", x_wr.din, exp_x.pop_front());
                end
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the packet flow stalled", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic run_packet(input int idx);
        pkt_entry_t e;
        int         depth;
        int         err_before;
        word_t      w;
        word_t      pkt_words [$];
        e          = pkt_table[idx];
        depth      = pkt_depth(e.len_code, e.short_depth);
        err_before = n_errors;
        // header at address 0 and random payload behind it
        for (int a = 0; a <= depth; a++) begin
            if (a == 0) begin
                w = {e.pkt_type, e.len_code,
                     {e.short_depth, 15'd0} | {8'd0, e.basis_count}};
            end else begin
                w = $urandom;
            end
            bram.mem[a[10:0]] = w;
            pkt_words.push_back(w);
        end
        case (e.pkt_type)
            ask_parity, verif_hashtag: begin
                for (int a = 0; a <= depth; a++) begin
                    exp_er.push_back(pkt_words[a]);
                end
            end
            z_basis: begin
                for (int a = 1; a <= depth; a++) begin
                    exp_z.push_back(pkt_words[a]);
                end
            end
            x_basis: begin
                // earlier word of each pair on top
                for (int a = 2; a <= depth; a += 2) begin
                    exp_x.push_back({pkt_words[a-1], pkt_words[a]});
                end
            end
            default: begin
            end
        endcase
        // header word has to reach the reader's data register
        repeat (3) @(negedge clk);
        msg_accessed = 1'b1;
        if (e.hold != 0) begin
            busy_net = 1'b1;
            repeat (e.hold) begin
                @(negedge clk);
                check_value("busy", 64'(busy), 64'd0);
            end
            busy_net = 1'b0;
        end
        while (!busy) @(negedge clk);
        while (unpack_state != wait_release) begin
            check_value("busy", 64'(busy), 64'd1);
            @(negedge clk);
        end
        // fsm holds while the packet is still offered
        repeat (2) begin
            @(negedge clk);
            check_value("unpack_state", 64'(unpack_state), 64'(wait_release));
            check_value("busy", 64'(busy), 64'd1);
        end
        check_value("sift_full", 64'(sift_full), 64'(e.exp_sift));
        msg_accessed = 1'b0;
        @(negedge clk);
        check_value("unpack_state", 64'(unpack_state), 64'(idle));
        check_value("busy", 64'(busy), 64'd0);
        check_value("z_wr writes missing", 64'(exp_z.size()), 64'd0);
        check_value("er_wr writes missing", 64'(exp_er.size()), 64'd0);
        check_value("x_wr writes missing", 64'(exp_x.size()), 64'd0);
        $display("packet %0d type %0d depth %0d: %s", idx, e.pkt_type, depth,
                 (n_errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        int passed;
        int err_before;
        passed = 0;
        void'($urandom(32'h9507_0442));
        rst_n        = 1'b0;
        busy_net     = 1'b0;
        msg_accessed = 1'b0;
        reset_sift   = 1'b0;
        // odd short depth leaks into bit 15 of the basis count
        pkt_table[0] = '{z_basis,       len_257, 9'd9, 16'd31, 4'd0, 1'b0};
        pkt_table[1] = '{ask_parity,    len_257, 9'd6, 16'd0,  4'd0, 1'b0};
        pkt_table[2] = '{verif_hashtag, len_257, 9'd6, 16'd0,  4'd4, 1'b0};
        pkt_table[3] = '{x_basis,       len_514, 9'd0, 16'd63, 4'd0, 1'b0};
        pkt_table[4] = '{z_basis,       len_257, 9'd8, 16'd31, 4'd0, 1'b1};
        pkt_table[5] = '{4'd9,          len_257, 9'd5, 16'd0,  4'd0, 1'b1};
        limit = 200;
        for (int i = 0; i < num_pkts; i++) begin
            limit += pkt_depth(pkt_table[i].len_code, pkt_table[i].short_depth) + 20;
        end
        // background pattern over every address bit
        for (int a = 0; a < 2048; a++) begin
            bram.mem[a] = {a[10:0], 10'h2a5, a[10:0]};
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        err_before = n_errors;
        check_value("unpack_state", 64'(unpack_state), 64'(idle));
        check_value("busy", 64'(busy), 64'd0);
        check_value("bram_addr", 64'(bram_addr), 64'd0);
        check_value("fifo enables", 64'({z_wr.en, er_wr.en, x_wr.en}), 64'd0);
        check_value("sift_full", 64'(sift_full), 64'd0);
        $display("reset values: %s", (n_errors == err_before) ? "ok" : "failed");
        for (int i = 0; i < num_pkts; i++) begin
            err_before = n_errors;
            run_packet(i);
            if (n_errors == err_before) passed++;
        end
        // clear the basis counts
        err_before = n_errors;
        reset_sift = 1'b1;
        @(negedge clk);
        reset_sift = 1'b0;
        check_value("sift_full", 64'(sift_full), 64'd0);
        $display("sift reset: %s", (n_errors == err_before) ? "ok" : "failed");
        $display("packets ok %0d of %0d, checks %0d, errors %0d",
                 passed, num_pkts, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/unpack_pkg.sv
design/unpack_fsm.sv
design/bram_reader.sv
design/fifo_router.sv
design/unpacket_top.sv
verif/rx_bram_model.sv
verif/tb_unpacket.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the unpacker testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_unpacket -o sim_unpacket > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_unpacket > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1
